// ==== build.f ====
design/rr_pkg.sv
design/rr_mem_if.sv
design/rr_csr.sv
design/rr_writeback.sv
design/rr_replay_reader.sv
design/rr_log_mem.sv
design/rr_storage_backend.sv
verification/rr_storage_backend_checker.sv
verification/rr_storage_backend_tb.sv

// ==== design/rr_csr.sv ====
`timescale 1ns/1ps

module rr_csr (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cfg_req,
  input  logic                      cfg_write,
  input  logic [rr_pkg::CFG_AW-1:0] cfg_addr,
  input  logic [rr_pkg::CFG_DW-1:0] cfg_wdata,
  output logic                      cfg_ack,
  output logic [rr_pkg::CFG_DW-1:0] cfg_rdata,
  output rr_pkg::rr_cfg_t           cfg,
  input  rr_pkg::rr_wb_stat_t       wb_stat,
  input  rr_pkg::rr_rd_stat_t       rd_stat
);

  rr_pkg::rr_reg_e           reg_sel;
  logic                      record_en;
  logic                      replay_en;
  logic                      flush_q;
  logic [rr_pkg::ADDR_W-1:0] base;
  logic [rr_pkg::ADDR_W:0]   limit;
  logic [rr_pkg::CFG_DW-1:0] rdata_d;
  logic                      access;

  assign reg_sel = rr_pkg::rr_reg_e'(cfg_addr);
  // First cycle of a request, ack not yet up
  assign access = cfg_req && !cfg_ack;

  // Read mux, zero extended
  always_comb begin
    rdata_d = '0;
    case (reg_sel)
      rr_pkg::REG_CTRL: begin
        rdata_d[rr_pkg::CTRL_RECORD] = record_en;
        rdata_d[rr_pkg::CTRL_REPLAY] = replay_en;
      end
      rr_pkg::REG_BASE:  rdata_d[rr_pkg::ADDR_W-1:0] = base;
      rr_pkg::REG_LIMIT: rdata_d[rr_pkg::ADDR_W:0] = limit;
      rr_pkg::REG_WORDS: rdata_d[rr_pkg::ADDR_W:0] = wb_stat.words;
      rr_pkg::REG_BITS:  rdata_d[rr_pkg::CNT_W-1:0] = wb_stat.bits;
      rr_pkg::REG_STAT: begin
        rdata_d[0] = rd_stat.done;
        rdata_d[1] = wb_stat.full;
      end
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_ack   <= 1'b0;
      cfg_rdata <= '0;
      record_en <= 1'b0;
      replay_en <= 1'b0;
      flush_q   <= 1'b0;
      base      <= '0;
      limit     <= '0;
    end else begin
      // Flush lasts one cycle
      flush_q <= 1'b0;
      if (access) begin
        // Writes land on the edge where ack rises
        cfg_ack   <= 1'b1;
        cfg_rdata <= rdata_d;
        if (cfg_write) begin
          case (reg_sel)
            rr_pkg::REG_CTRL: begin
              record_en <= cfg_wdata[rr_pkg::CTRL_RECORD];
              replay_en <= cfg_wdata[rr_pkg::CTRL_REPLAY];
              flush_q   <= cfg_wdata[rr_pkg::CTRL_FLUSH];
            end
            rr_pkg::REG_BASE:  base <= cfg_wdata[rr_pkg::ADDR_W-1:0];
            rr_pkg::REG_LIMIT: limit <= cfg_wdata[rr_pkg::ADDR_W:0];
            // Status registers ignore writes
            default: ;
          endcase
        end
      end else if (!cfg_req && cfg_ack) begin
        cfg_ack <= 1'b0;
      end
    end
  end

  assign cfg.record_en = record_en;
  assign cfg.replay_en = replay_en;
  assign cfg.flush     = flush_q;
  assign cfg.base      = base;
  assign cfg.limit     = limit;

endmodule

// ==== design/rr_log_mem.sv ====
`timescale 1ns/1ps

module rr_log_mem (
  input  logic     clk,
  input  logic     rst_n,
  rr_mem_if.slave  wr,
  rr_mem_if.slave  rd
);

  logic [rr_pkg::WORD_W-1:0] mem_array [2**rr_pkg::ADDR_W];

  // Handshake on both ports, ack one cycle after req
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr.ack <= 1'b0;
      rd.ack <= 1'b0;
    end else begin
      wr.ack <= wr.req;
      rd.ack <= rd.req;
    end
  end

  // Access happens once, on the cycle before ack rises
  always_ff @(posedge clk) begin
    if (wr.req && !wr.ack) begin
      mem_array[wr.addr] <= wr.wdata;
    end
    if (rd.req && !rd.ack) begin
      rd.rdata <= mem_array[rd.addr];
    end
  end

  // Write port returns no data
  assign wr.rdata = '0;

endmodule

// ==== design/rr_mem_if.sv ====
`timescale 1ns/1ps

interface rr_mem_if;

  // Four-phase word access
  logic                      req;
  logic                      ack;
  logic [rr_pkg::ADDR_W-1:0] addr;
  logic [rr_pkg::WORD_W-1:0] wdata;
  // Valid while ack is high
  logic [rr_pkg::WORD_W-1:0] rdata;

  modport master (
    output req,
    output addr,
    output wdata,
    input  ack,
    input  rdata
  );

  modport slave (
    input  req,
    input  addr,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

// ==== design/rr_pkg.sv ====
package rr_pkg;

  // Channel layout of one logging unit
  localparam int LOGB_CNT = 3;
  localparam int LOGE_CNT = 2;
  // Channel widths, index 0 is the lowest channel
  localparam logic [LOGB_CNT-1:0][7:0] CHAN_W = {8'd24, 8'd16, 8'd8};

  // Widest unit: bitmap, events and every channel
  localparam int FULL_W = LOGB_CNT + LOGE_CNT + 8 + 16 + 24;
  localparam int LEN_W = 6;

  // Log memory geometry
  localparam int WORD_W = 64;
  localparam int ADDR_W = 8;
  localparam int CNT_W = 16;

  // Bit buffers hold one word plus one full unit
  localparam int BUF_W = WORD_W + FULL_W;
  localparam int FILL_W = 7;

  // Configuration bus
  localparam int CFG_AW = 3;
  localparam int CFG_DW = 32;

  // Register map
  typedef enum logic [CFG_AW-1:0] {
    REG_CTRL  = 3'd0,
    REG_BASE  = 3'd1,
    REG_LIMIT = 3'd2,
    REG_WORDS = 3'd3,
    REG_BITS  = 3'd4,
    REG_STAT  = 3'd5
  } rr_reg_e;

  // Bit positions inside REG_CTRL
  typedef enum int unsigned {
    CTRL_RECORD = 0,
    CTRL_REPLAY = 1,
    CTRL_FLUSH  = 2
  } rr_ctrl_bit_e;

  typedef struct packed {
    logic              record_en;
    logic              replay_en;
    // Single cycle pulse
    logic              flush;
    logic [ADDR_W-1:0] base;
    // Window size in words, 256 needs the extra bit
    logic [ADDR_W:0]   limit;
  } rr_cfg_t;

  typedef struct packed {
    logic [ADDR_W:0]  words;
    logic [CNT_W-1:0] bits;
    logic             full;
  } rr_wb_stat_t;

  typedef struct packed {
    logic done;
  } rr_rd_stat_t;

  // Unit length from its bitmap: bitmap and events plus each valid channel
  function automatic logic [LEN_W-1:0] unit_len(input logic [LOGB_CNT-1:0] bitmap);
    logic [LEN_W-1:0] len;
    len = LEN_W'(LOGB_CNT + LOGE_CNT);
    for (int i = 0; i < LOGB_CNT; i++) begin
      if (bitmap[i]) begin
        len = len + LEN_W'(CHAN_W[i]);
      end
    end
    return len;
  endfunction

endpackage

// ==== design/rr_replay_reader.sv ====
`timescale 1ns/1ps

module rr_replay_reader (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rr_pkg::rr_cfg_t           cfg,
  input  rr_pkg::rr_wb_stat_t       wb_stat,
  output rr_pkg::rr_rd_stat_t       rd_stat,
  rr_mem_if.master                  mem,
  output logic                      replay_valid,
  output logic [rr_pkg::FULL_W-1:0] replay_data,
  output logic [rr_pkg::LEN_W-1:0]  replay_len,
  input  logic                      replay_ready
);

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    RELEASE,
    EMIT,
    DONE
  } rd_state_e;

  rd_state_e                 state;
  // Next unit always starts at bit 0
  logic [rr_pkg::BUF_W-1:0]  bit_buf;
  logic [rr_pkg::FILL_W-1:0] cnt;
  logic [rr_pkg::ADDR_W:0]   rd_words;
  logic [rr_pkg::CNT_W-1:0]  consumed;
  logic [rr_pkg::LEN_W-1:0]  len;
  logic [rr_pkg::BUF_W-1:0]  word_ext;
  logic                      have_map;
  logic                      unit_ok;
  logic                      at_end;
  logic                      need_word;
  logic                      start_fetch;
  logic                      pop;

  assign len      = rr_pkg::unit_len(bit_buf[rr_pkg::LOGB_CNT-1:0]);
  assign word_ext = {{(rr_pkg::BUF_W - rr_pkg::WORD_W){1'b0}}, mem.rdata};

  // Length is known once the bitmap is in
  assign have_map  = cnt >= rr_pkg::LOGB_CNT;
  assign unit_ok   = have_map && (cnt >= {1'b0, len});
  // Stop at the recorded bit count, padding is never parsed
  assign at_end    = consumed == wb_stat.bits;
  assign need_word = (cnt < rr_pkg::FULL_W) && (rd_words < wb_stat.words);

  // A waiting unit goes out before any new fetch
  assign start_fetch = (state == EMIT) && !at_end && !unit_ok && need_word;

  assign replay_valid = (state == EMIT) && unit_ok && !at_end;
  assign replay_len   = len;
  // Zero above the unit so later fetches never show through
  assign replay_data  = bit_buf[rr_pkg::FULL_W-1:0] & ~({rr_pkg::FULL_W{1'b1}} << len);
  assign pop          = replay_valid && replay_ready;

  assign rd_stat.done = state == DONE;
  // Read-only port
  assign mem.wdata    = '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      bit_buf  <= '0;
      cnt      <= '0;
      rd_words <= '0;
      consumed <= '0;
      mem.req  <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (cfg.replay_en) begin
            state <= EMIT;
          end
        end
        EMIT: begin
          if (at_end) begin
            state <= DONE;
          end else if (pop) begin
            bit_buf  <= bit_buf >> len;
            cnt      <= cnt - {1'b0, len};
            consumed <= consumed + {{(rr_pkg::CNT_W - rr_pkg::LEN_W){1'b0}}, len};
          end else if (start_fetch) begin
            mem.req <= 1'b1;
            state   <= FETCH;
          end
          // Otherwise wait for the writer to add words
        end
        FETCH: begin
          if (mem.ack) begin
            // Append the word above the bits still buffered
            bit_buf  <= bit_buf | (word_ext << cnt);
            cnt      <= cnt + 7'd64;
            rd_words <= rd_words + 1'b1;
            mem.req  <= 1'b0;
            state    <= RELEASE;
          end
        end
        RELEASE: begin
          if (!mem.ack) begin
            state <= EMIT;
          end
        end
        DONE: begin
          // Done stays up until replay is switched off
          if (!cfg.replay_en) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Word address held through the request
  always_ff @(posedge clk) begin
    if (start_fetch) begin
      mem.addr <= cfg.base + rd_words[rr_pkg::ADDR_W-1:0];
    end
  end

endmodule

// ==== design/rr_storage_backend.sv ====
`timescale 1ns/1ps

module rr_storage_backend (
  input  logic                      clk,
  input  logic                      rst_n,
  // Configuration bus
  input  logic                      cfg_req,
  output logic                      cfg_ack,
  input  logic                      cfg_write,
  input  logic [rr_pkg::CFG_AW-1:0] cfg_addr,
  input  logic [rr_pkg::CFG_DW-1:0] cfg_wdata,
  output logic [rr_pkg::CFG_DW-1:0] cfg_rdata,
  // Record stream
  input  logic                      record_valid,
  output logic                      record_ready,
  input  logic [rr_pkg::FULL_W-1:0] record_data,
  // Replay stream
  output logic                      replay_valid,
  input  logic                      replay_ready,
  output logic [rr_pkg::FULL_W-1:0] replay_data,
  output logic [rr_pkg::LEN_W-1:0]  replay_len
);

  rr_pkg::rr_cfg_t     cfg;
  rr_pkg::rr_wb_stat_t wb_stat;
  rr_pkg::rr_rd_stat_t rd_stat;

  // One port per engine
  rr_mem_if wr_port ();
  rr_mem_if rd_port ();

  rr_csr rr_csr_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_req   (cfg_req),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata),
    .cfg       (cfg),
    .wb_stat   (wb_stat),
    .rd_stat   (rd_stat)
  );

  rr_writeback rr_writeback_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .record_valid (record_valid),
    .record_data  (record_data),
    .record_ready (record_ready),
    .cfg          (cfg),
    .stat         (wb_stat),
    .mem          (wr_port.master)
  );

  // Reader follows the writer's word and bit counts
  rr_replay_reader rr_replay_reader_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .wb_stat      (wb_stat),
    .rd_stat      (rd_stat),
    .mem          (rd_port.master),
    .replay_valid (replay_valid),
    .replay_data  (replay_data),
    .replay_len   (replay_len),
    .replay_ready (replay_ready)
  );

  rr_log_mem rr_log_mem_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr_port.slave),
    .rd    (rd_port.slave)
  );

endmodule

// ==== design/rr_writeback.sv ====
`timescale 1ns/1ps

module rr_writeback (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      record_valid,
  input  logic [rr_pkg::FULL_W-1:0] record_data,
  output logic                      record_ready,
  input  rr_pkg::rr_cfg_t           cfg,
  output rr_pkg::rr_wb_stat_t       stat,
  rr_mem_if.master                  mem
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE_REQ,
    WRITE_RELEASE
  } wb_state_e;

  wb_state_e                 state;
  // Accumulator, oldest bit at position 0
  logic [rr_pkg::BUF_W-1:0]  acc;
  logic [rr_pkg::FILL_W-1:0] fill;
  logic                      flush_pend;
  logic [rr_pkg::LEN_W-1:0]  len;
  logic [rr_pkg::FULL_W-1:0] unit_bits;
  logic [rr_pkg::BUF_W-1:0]  unit_ext;
  logic                      take;
  logic                      room;
  logic                      launch;
  logic                      word_full;

  assign len = rr_pkg::unit_len(record_data[rr_pkg::LOGB_CNT-1:0]);
  // Drop anything above the unit length
  assign unit_bits = record_data & ~({rr_pkg::FULL_W{1'b1}} << len);
  assign unit_ext  = {{(rr_pkg::BUF_W - rr_pkg::FULL_W){1'b0}}, unit_bits};

  assign word_full = fill >= rr_pkg::WORD_W;
  assign room      = stat.words < cfg.limit;

  // Below one word buffered there is room for a full unit
  assign record_ready = (state == IDLE) && cfg.record_en && !stat.full &&
                        !word_full && !flush_pend;
  assign take = record_valid && record_ready;

  // Full word first, partial word only on flush
  assign launch = (state == IDLE) && room &&
                  (word_full || (flush_pend && (fill != '0)));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      acc        <= '0;
      fill       <= '0;
      flush_pend <= 1'b0;
      mem.req    <= 1'b0;
      stat       <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (take) begin
            acc       <= acc | (unit_ext << fill);
            fill      <= fill + {1'b0, len};
            stat.bits <= stat.bits + {{(rr_pkg::CNT_W - rr_pkg::LEN_W){1'b0}}, len};
          end else if (launch) begin
            // Zeros shift in, so a partial word is already padded
            acc     <= acc >> rr_pkg::WORD_W;
            fill    <= word_full ? fill - 7'd64 : '0;
            mem.req <= 1'b1;
            state   <= WRITE_REQ;
            if (!word_full) begin
              flush_pend <= 1'b0;
            end
          end else if (flush_pend && (fill == '0)) begin
            // Nothing left to pad
            flush_pend <= 1'b0;
          end
        end
        WRITE_REQ: begin
          if (mem.ack) begin
            mem.req    <= 1'b0;
            stat.words <= stat.words + 1'b1;
            if (stat.words + 1'b1 >= cfg.limit) begin
              stat.full <= 1'b1;
            end
            state <= WRITE_RELEASE;
          end
        end
        WRITE_RELEASE: begin
          // Next request only after ack falls
          if (!mem.ack) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
      // A new flush request wins over the clear above
      if (cfg.flush) begin
        flush_pend <= 1'b1;
      end
    end
  end

  // Address and data held for the whole request
  always_ff @(posedge clk) begin
    if (launch) begin
      mem.wdata <= acc[rr_pkg::WORD_W-1:0];
      mem.addr  <= cfg.base + stat.words[rr_pkg::ADDR_W-1:0];
    end
  end

endmodule

// ==== verification/rr_storage_backend_checker.sv ====
`timescale 1ns/1ps

module rr_storage_backend_checker (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      cfg_req,
  input logic                      cfg_ack,
  input logic                      record_ready,
  input logic                      replay_valid,
  input logic                      replay_ready,
  input logic [rr_pkg::FULL_W-1:0] replay_data
);

  // Ack drops only after the request went away
  cfg_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cfg_ack) |-> !$past(cfg_req))
    else $error("cfg_ack fell while cfg_req was still high");

  // Stalled unit keeps its data and stays valid
  replay_hold: assert property (@(posedge clk) disable iff (!rst_n)
    replay_valid && !replay_ready |=> replay_valid && $stable(replay_data))
    else $error("replay unit changed or vanished while stalled");

  // Both streams quiet in reset
  reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !replay_valid && !record_ready)
    else $error("stream handshake active during reset");

endmodule

bind rr_storage_backend rr_storage_backend_checker rr_storage_backend_checker_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .cfg_req      (cfg_req),
  .cfg_ack      (cfg_ack),
  .record_ready (record_ready),
  .replay_valid (replay_valid),
  .replay_ready (replay_ready),
  .replay_data  (replay_data)
);

// ==== verification/rr_storage_backend_tb.sv ====
`timescale 1ns/1ps

module rr_storage_backend_tb;

  logic                      clk;
  logic                      rst_n;
  logic                      cfg_req;
  logic                      cfg_ack;
  logic                      cfg_write;
  logic [rr_pkg::CFG_AW-1:0] cfg_addr;
  logic [rr_pkg::CFG_DW-1:0] cfg_wdata;
  logic [rr_pkg::CFG_DW-1:0] cfg_rdata;
  logic                      record_valid;
  logic                      record_ready;
  logic [rr_pkg::FULL_W-1:0] record_data;
  logic                      replay_valid;
  logic                      replay_ready;
  logic [rr_pkg::FULL_W-1:0] replay_data;
  logic [rr_pkg::LEN_W-1:0]  replay_len;

  // LCG state
  logic [31:0]               rng_state = 32'h20c6_6545;
  // Reference model of masked units in record order
  logic [rr_pkg::FULL_W-1:0] unit_q[$];
  // Model bit total of accepted units
  int                        total_bits;

  rr_storage_backend rr_storage_backend_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_req      (cfg_req),
    .cfg_ack      (cfg_ack),
    .cfg_write    (cfg_write),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .record_valid (record_valid),
    .record_ready (record_ready),
    .record_data  (record_data),
    .replay_valid (replay_valid),
    .replay_ready (replay_ready),
    .replay_data  (replay_data),
    .replay_len   (replay_len)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // 5 header bits plus 8, 16, 24 for channels 0, 1, 2
  function automatic int model_len(input logic [2:0] bitmap);
    int len;
    len = 5;
    if (bitmap[0]) len += 8;
    if (bitmap[1]) len += 16;
    if (bitmap[2]) len += 24;
    return len;
  endfunction

  // Clear every bit at or above the unit length
  function automatic logic [rr_pkg::FULL_W-1:0] mask_unit(input logic [rr_pkg::FULL_W-1:0] raw);
    logic [rr_pkg::FULL_W-1:0] unit;
    int                        len;
    unit = raw;
    len  = model_len(raw[2:0]);
    for (int b = 0; b < rr_pkg::FULL_W; b++) begin
      if (b >= len) unit[b] = 1'b0;
    end
    return unit;
  endfunction

  // Upper LCG bits only since the low bits cycle too fast
  function automatic logic [rr_pkg::FULL_W-1:0] random_unit();
    logic [rr_pkg::FULL_W-1:0] u;
    logic [31:0]               r;
    u = '0;
    for (int k = 0; k < 4; k++) begin
      r = next_rand();
      u = {u[rr_pkg::FULL_W-17:0], r[31:16]};
    end
    return u;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("error: %s got 0x%0h expected 0x%0h", name, actual, expected);
      $display("Simulation FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Simulation FAILED");
    $fatal(1, "timeout");
  endtask

  // Ten cycles of reset and a clean model
  task automatic apply_reset();
    @(posedge clk);
    rst_n        <= 1'b0;
    cfg_req      <= 1'b0;
    record_valid <= 1'b0;
    replay_ready <= 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    unit_q.delete();
    total_bits = 0;
  endtask

  // Ack sampled on the falling edge
  task automatic wait_cfg_ack(input logic level);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 50) fail_timeout("cfg_ack did not reach the expected level");
    end while (cfg_ack !== level);
  endtask

  // One four-phase cfg transfer
  task automatic cfg_access(input logic is_write, input logic [2:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    cfg_req   <= 1'b1;
    cfg_write <= is_write;
    cfg_addr  <= addr;
    cfg_wdata <= wdata;
    wait_cfg_ack(1'b1);
    // Read data is valid while ack is high
    rdata = cfg_rdata;
    @(posedge clk);
    cfg_req <= 1'b0;
    wait_cfg_ack(1'b0);
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    cfg_access(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
    cfg_access(1'b0, addr, '0, data);
  endtask

  // Reread until the masked field matches or the tries run out
  task automatic poll_reg(input logic [2:0] addr, input logic [31:0] mask,
                          input logic [31:0] want, output logic [31:0] got);
    int tries;
    tries = 0;
    do begin
      read_reg(addr, got);
      tries++;
    end while (((got & mask) != want) && tries < 100);
  endtask

  // Holds valid until ready or until max_wait cycles pass
  task automatic send_unit(input logic [rr_pkg::FULL_W-1:0] raw, input int max_wait,
                           output logic accepted);
    int cycles;
    cycles   = 0;
    accepted = 1'b1;
    @(posedge clk);
    record_valid <= 1'b1;
    record_data  <= raw;
    @(negedge clk);
    while (!record_ready) begin
      cycles++;
      if (cycles > max_wait) begin
        accepted = 1'b0;
        break;
      end
      @(negedge clk);
    end
    // Transfer happens on this edge when ready was seen
    @(posedge clk);
    record_valid <= 1'b0;
  endtask

  task automatic check_registers();
    logic [31:0] got;
    logic [7:0]  base_v;
    logic [8:0]  limit_v;
    // Status counters start at zero
    read_reg(rr_pkg::REG_WORDS, got);
    check_value("REG_WORDS", got, 0);
    read_reg(rr_pkg::REG_BITS, got);
    check_value("REG_BITS", got, 0);
    read_reg(rr_pkg::REG_STAT, got);
    check_value("REG_STAT", got, 0);
    base_v  = 8'(next_rand() >> 24);
    limit_v = 9'(next_rand() >> 23);
    write_reg(rr_pkg::REG_BASE, {24'b0, base_v});
    write_reg(rr_pkg::REG_LIMIT, {23'b0, limit_v});
    read_reg(rr_pkg::REG_BASE, got);
    check_value("REG_BASE", got, {24'b0, base_v});
    read_reg(rr_pkg::REG_LIMIT, got);
    check_value("REG_LIMIT", got, {23'b0, limit_v});
  endtask

  task automatic record_and_replay(input logic stall);
    logic [rr_pkg::FULL_W-1:0] raw;
    logic [rr_pkg::FULL_W-1:0] exp_unit;
    logic [31:0]               got;
    logic                      accepted;
    int                        cycles;
    write_reg(rr_pkg::REG_BASE, next_rand() >> 25);
    write_reg(rr_pkg::REG_LIMIT, 100);
    write_reg(rr_pkg::REG_CTRL, 1 << rr_pkg::CTRL_RECORD);
    for (int i = 0; i < 40; i++) begin
      raw = random_unit();
      send_unit(raw, 200, accepted);
      if (!accepted) fail_timeout("record_ready stayed low for a unit");
      unit_q.push_back(mask_unit(raw));
      total_bits += model_len(raw[2:0]);
      // Random gap between units
      repeat ((next_rand() >> 20) % 4) @(posedge clk);
    end
    // Flush pushes out the padded last word
    write_reg(rr_pkg::REG_CTRL, (1 << rr_pkg::CTRL_RECORD) | (1 << rr_pkg::CTRL_FLUSH));
    poll_reg(rr_pkg::REG_WORDS, 32'hffff_ffff, (total_bits + 63) / 64, got);
    check_value("REG_WORDS", got, (total_bits + 63) / 64);
    read_reg(rr_pkg::REG_BITS, got);
    check_value("REG_BITS", got, total_bits);

    write_reg(rr_pkg::REG_CTRL, 1 << rr_pkg::CTRL_REPLAY);
    cycles = 0;
    while (unit_q.size() > 0) begin
      @(posedge clk);
      replay_ready <= stall ? next_rand() >> 31 : 1'b1;
      @(negedge clk);
      // Unit transfers on the coming edge
      if (replay_valid && replay_ready) begin
        exp_unit = unit_q.pop_front();
        check_value("replay_len", replay_len, model_len(exp_unit[2:0]));
        check_value("replay_data", replay_data, exp_unit);
        cycles = 0;
      end else begin
        cycles++;
        if (cycles > 500) fail_timeout("replay unit did not arrive");
      end
    end
    @(posedge clk);
    replay_ready <= 1'b0;
    poll_reg(rr_pkg::REG_STAT, 32'h1, 32'h1, got);
    check_value("REG_STAT done", got[0], 1'b1);
    // No extra unit after the last one
    check_value("replay_valid", replay_valid, 1'b0);
  endtask

  task automatic fill_window();
    logic [rr_pkg::FULL_W-1:0] raw;
    logic [31:0]               got;
    logic                      accepted;
    int                        sent;
    // Four word window near the top of memory
    write_reg(rr_pkg::REG_BASE, 32'hf0);
    write_reg(rr_pkg::REG_LIMIT, 4);
    write_reg(rr_pkg::REG_CTRL, 1 << rr_pkg::CTRL_RECORD);
    sent     = 0;
    accepted = 1'b1;
    while (accepted && sent < 100) begin
      raw = random_unit();
      send_unit(raw, 40, accepted);
      if (accepted) begin
        total_bits += model_len(raw[2:0]);
        sent++;
      end
    end
    check_value("record stalled", accepted, 1'b0);
    // Ready must stay low once the window is full
    repeat (20) begin
      @(negedge clk);
      check_value("record_ready", record_ready, 1'b0);
    end
    read_reg(rr_pkg::REG_WORDS, got);
    check_value("REG_WORDS", got, 4);
    read_reg(rr_pkg::REG_STAT, got);
    check_value("REG_STAT full", got[1], 1'b1);
    read_reg(rr_pkg::REG_BITS, got);
    check_value("REG_BITS", got, total_bits);
  endtask

  initial begin
    rst_n        <= 1'b0;
    cfg_req      <= 1'b0;
    cfg_write    <= 1'b0;
    cfg_addr     <= '0;
    cfg_wdata    <= '0;
    record_valid <= 1'b0;
    record_data  <= '0;
    replay_ready <= 1'b0;
    total_bits = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    check_registers();
    // Free-running sink first and random stalls after
    record_and_replay(1'b0);
    apply_reset();
    record_and_replay(1'b1);
    apply_reset();
    fill_window();
    $display("Simulation PASSED");
    $finish;
  end

endmodule
